/* src.f */
interconnect_pkg.sv
periph_bus_if.sv
addr_decode.sv
load_align.sv
read_return.sv
tohost_unit.sv
soc_interconnect.sv
tb_soc_interconnect.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; a $fatal gives a failing exit status
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_soc_interconnect -f src.f

./obj_dir/Vtb_soc_interconnect

/* tb_soc_interconnect.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_interconnect
    import interconnect_pkg::*;
();

    localparam int    OFFSET_BITS  = DRAM_OFFSET_BITS_DEFAULT;
    localparam int    NUM_CYCLES   = 2000;
    localparam int    RESET_CYCLES = 5;
    localparam int    TIMEOUT_NS   = (RESET_CYCLES + NUM_CYCLES + 100) * 10;
    localparam addr_t DRAM_MASK    = {{(32 - OFFSET_BITS){1'b0}}, {OFFSET_BITS{1'b1}}};
    localparam addr_t IDLE_ADDR    = 32'h3000_0000;

    logic       CLK = 1'b0;
    logic       rst_n;
    addr_t      cpu_addr;
    data_t      cpu_wdata;
    logic       cpu_we;
    logic       cpu_re;
    ctrl_t      cpu_ctrl;
    logic       dram_busy;
    line_t      dram_rdata;
    data_t      plic_rdata;
    data_t      clint_rdata;
    logic       dram_rd_en;
    logic       dram_wr_en;
    addr_t      dram_addr;
    data_t      dram_wdata;
    ctrl_t      dram_ctrl;
    logic       plic_we;
    logic       plic_re;
    data_t      plic_wdata;
    logic       clint_we;
    logic       clint_re;
    data_t      clint_wdata;
    data_t      read_data;
    logic       is_dram_data;
    logic       uart_we;
    logic [7:0] uart_data;
    logic       finish;

    int         seed;
    line_t      mem [16];

    // Reference model history
    dev_e       last_dev;
    logic       last_read;
    logic [3:0] last_off;
    logic [3:0] last_idx;
    ctrl_t      last_ctrl;
    logic       pr1;
    logic       pr2;
    logic [7:0] pb1;
    logic [7:0] pb2;
    logic       pw1;
    logic       pw2;
    logic       fin_sticky;

    soc_interconnect #(
        .DRAM_OFFSET_BITS (OFFSET_BITS)
    ) u_dut (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .cpu_addr     (cpu_addr),
        .cpu_wdata    (cpu_wdata),
        .cpu_we       (cpu_we),
        .cpu_re       (cpu_re),
        .cpu_ctrl     (cpu_ctrl),
        .read_data    (read_data),
        .is_dram_data (is_dram_data),
        .dram_busy    (dram_busy),
        .dram_rdata   (dram_rdata),
        .dram_rd_en   (dram_rd_en),
        .dram_wr_en   (dram_wr_en),
        .dram_addr    (dram_addr),
        .dram_wdata   (dram_wdata),
        .dram_ctrl    (dram_ctrl),
        .plic_rdata   (plic_rdata),
        .plic_we      (plic_we),
        .plic_re      (plic_re),
        .plic_wdata   (plic_wdata),
        .clint_rdata  (clint_rdata),
        .clint_we     (clint_we),
        .clint_re     (clint_re),
        .clint_wdata  (clint_wdata),
        .uart_we      (uart_we),
        .uart_data    (uart_data),
        .finish       (finish)
    );

    always #5 CLK = ~CLK;

    initial begin
        #(TIMEOUT_NS);
        $display("test failed");
        $fatal(1, "Watchdog timeout: the run did not complete in time");
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] time=%0t signal=%s expected=0x%08h actual=0x%08h",
                     $time, name, expected, actual);
            $display("test failed");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    function automatic line_t random_line();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // Memory map, tohost is an exact word match
    function automatic dev_e region_of(input addr_t a);
        if (a == TOHOST_ADDR) begin
            return DEV_TOHOST;
        end
        case (a[31:28])
            4'h0, 4'h8: return DEV_DRAM;
            4'h5:       return DEV_PLIC;
            4'h6:       return DEV_CLINT;
            default:    return DEV_NONE;
        endcase
    endfunction

    // Expected load value from a DRAM line
    function automatic data_t extract_load(input line_t line, input logic [3:0] off,
                                           input ctrl_t ctrl);
        int          base;
        logic [7:0]  b;
        logic [15:0] h;
        base = int'(off) * 8;
        b = line[base +: 8];
        case (ctrl[1:0])
            2'd0: begin
                return ctrl[2] ? {24'd0, b} : {{24{b[7]}}, b};
            end
            2'd1: begin
                h = line[base +: 16];
                return ctrl[2] ? {16'd0, h} : {{16{h[15]}}, h};
            end
            default: return line[base +: 32];
        endcase
    endfunction

    // One cycle of stimulus, checks at the falling edge, then model update
    task automatic run_cycle(input logic we, input logic re, input addr_t addr,
                             input data_t wdata, input ctrl_t ctrl, input logic busy);
        dev_e  d;
        data_t exp_word;
        logic  exp_rd;
        logic  exp_wr;
        @(posedge CLK);
        #1;
        cpu_we      = we;
        cpu_re      = re;
        cpu_addr    = addr;
        cpu_wdata   = wdata;
        cpu_ctrl    = ctrl;
        dram_busy   = busy;
        plic_rdata  = $random(seed);
        clint_rdata = $random(seed);
        if (last_read && last_dev == DEV_DRAM) begin
            dram_rdata = mem[last_idx];
        end else begin
            dram_rdata = random_line();
        end
        @(negedge CLK);
        d = region_of(addr);
        exp_rd = (d == DEV_DRAM) && re && !busy;
        exp_wr = (d == DEV_DRAM) && we && !busy;
        check_value("dram_rd_en", 32'(exp_rd), 32'(dram_rd_en));
        check_value("dram_wr_en", 32'(exp_wr), 32'(dram_wr_en));
        check_value("dram_addr", addr & DRAM_MASK, dram_addr);
        if (exp_rd || exp_wr) begin
            check_value("dram_ctrl", 32'(ctrl), 32'(dram_ctrl));
            check_value("dram_wdata", wdata, dram_wdata);
        end
        check_value("plic_we", 32'((d == DEV_PLIC) && we), 32'(plic_we));
        check_value("plic_re", 32'((d == DEV_PLIC) && re), 32'(plic_re));
        check_value("clint_we", 32'((d == DEV_CLINT) && we), 32'(clint_we));
        check_value("clint_re", 32'((d == DEV_CLINT) && re), 32'(clint_re));
        if (plic_we) begin
            check_value("plic_wdata", wdata, plic_wdata);
        end
        if (clint_we) begin
            check_value("clint_wdata", wdata, clint_wdata);
        end
        // Return path for the read of the previous cycle
        if (last_read) begin
            case (last_dev)
                DEV_DRAM:  exp_word = extract_load(mem[last_idx], last_off, last_ctrl);
                DEV_PLIC:  exp_word = plic_rdata;
                DEV_CLINT: exp_word = clint_rdata;
                default:   exp_word = '0;
            endcase
            check_value("read_data", exp_word, read_data);
        end
        check_value("is_dram_data", 32'(last_dev == DEV_DRAM), 32'(is_dram_data));
        check_value("uart_we", 32'(pr2), 32'(uart_we));
        if (pr2) begin
            check_value("uart_data", 32'(pb2), 32'(uart_data));
        end
        check_value("finish", 32'(fin_sticky | pw2), 32'(finish));
        last_dev   = d;
        last_read  = re && !((d == DEV_DRAM) && busy);
        last_off   = addr[3:0];
        last_idx   = addr[7:4];
        last_ctrl  = ctrl;
        fin_sticky = fin_sticky | pw2;
        pr2        = pr1;
        pb2        = pb1;
        pw2        = pw1;
        pr1        = we && (d == DEV_TOHOST) && (wdata[31:16] == CMD_PRINT_CHAR);
        pb1        = wdata[7:0];
        pw1        = we && (d == DEV_TOHOST) && (wdata[31:16] == CMD_POWER_OFF);
    endtask

    initial begin
        int          sel;
        logic [31:0] r;
        logic [3:0]  nib;
        logic        we;
        logic        re;
        logic        busy;
        logic        hold;
        addr_t       addr;
        data_t       wdata;
        ctrl_t       ctrl;
        seed        = 55952;
        rst_n       = 1'b0;
        cpu_addr    = IDLE_ADDR;
        cpu_wdata   = '0;
        cpu_we      = 1'b0;
        cpu_re      = 1'b0;
        cpu_ctrl    = CTRL_WORD;
        dram_busy   = 1'b0;
        dram_rdata  = '0;
        plic_rdata  = '0;
        clint_rdata = '0;
        for (int i = 0; i < 16; i++) begin
            mem[i] = random_line();
        end
        last_dev   = DEV_NONE;
        last_read  = 1'b0;
        last_off   = '0;
        last_idx   = '0;
        last_ctrl  = CTRL_WORD;
        pr1        = 1'b0;
        pr2        = 1'b0;
        pb1        = '0;
        pb2        = '0;
        pw1        = 1'b0;
        pw2        = 1'b0;
        fin_sticky = 1'b0;
        hold       = 1'b0;
        we         = 1'b0;
        re         = 1'b0;
        addr       = IDLE_ADDR;
        wdata      = '0;
        ctrl       = CTRL_WORD;

        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        rst_n = 1'b1;
        @(negedge CLK);
        check_value("uart_we", 32'd0, 32'(uart_we));
        check_value("finish", 32'd0, 32'(finish));
        check_value("is_dram_data", 32'd0, 32'(is_dram_data));

        for (int i = 0; i < NUM_CYCLES; i++) begin
            // A stalled DRAM request is held by the CPU
            if (!hold) begin
                r = $random(seed);
                sel = $unsigned($random(seed)) % 10;
                case (sel)
                    0, 1, 2, 3: addr = {r[31] ? 4'h8 : 4'h0, r[27:0]};
                    4, 5:       addr = {DEV_NIBBLE_PLIC, r[27:0]};
                    6, 7:       addr = {DEV_NIBBLE_CLINT, r[27:0]};
                    8:          addr = TOHOST_ADDR;
                    default: begin
                        nib = r[31:28];
                        if (nib == 4'h0 || nib == 4'h8 || nib == 4'h5 || nib == 4'h6) begin
                            nib = 4'hb;
                        end
                        addr = {nib, r[27:0]};
                    end
                endcase
                sel = $unsigned($random(seed)) % 5;
                case (sel)
                    0:       ctrl = 3'b000;
                    1:       ctrl = 3'b001;
                    2:       ctrl = 3'b010;
                    3:       ctrl = 3'b100;
                    default: ctrl = 3'b101;
                endcase
                // Natural alignment for the access size
                if (ctrl[1:0] == 2'd1) begin
                    addr[0] = 1'b0;
                end else if (ctrl[1:0] == 2'd2) begin
                    addr[1:0] = 2'b00;
                end
                sel = $unsigned($random(seed)) % 4;
                we  = (sel == 0);
                re  = (sel == 1) || (sel == 2);
                r   = $random(seed);
                if (addr == TOHOST_ADDR) begin
                    wdata = {CMD_PRINT_CHAR, r[15:0]};
                end else begin
                    wdata = r;
                end
            end
            busy = ($unsigned($random(seed)) % 4) == 0;
            run_cycle(we, re, addr, wdata, ctrl, busy);
            hold = busy && (we || re) && (region_of(addr) == DEV_DRAM);
        end

        // Power-off goes last, then idle until finish has risen
        r = $random(seed);
        run_cycle(1'b1, 1'b0, TOHOST_ADDR, {CMD_POWER_OFF, r[15:0]}, CTRL_WORD, 1'b0);
        repeat (6) run_cycle(1'b0, 1'b0, IDLE_ADDR, '0, CTRL_WORD, 1'b0);
        check_value("finish", 32'd1, 32'(finish));

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* soc_interconnect.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_interconnect
    import interconnect_pkg::*;
#(
    parameter int DRAM_OFFSET_BITS = DRAM_OFFSET_BITS_DEFAULT
) (
    input  wire        CLK,
    input  wire        rst_n,
    // CPU data port
    input  wire addr_t cpu_addr,
    input  wire data_t cpu_wdata,
    input  wire        cpu_we,
    input  wire        cpu_re,
    input  wire ctrl_t cpu_ctrl,
    output data_t      read_data,
    output logic       is_dram_data,
    // DRAM controller
    input  wire        dram_busy,
    input  wire line_t dram_rdata,
    output logic       dram_rd_en,
    output logic       dram_wr_en,
    output addr_t      dram_addr,
    output data_t      dram_wdata,
    output ctrl_t      dram_ctrl,
    // PLIC
    input  wire data_t plic_rdata,
    output logic       plic_we,
    output logic       plic_re,
    output data_t      plic_wdata,
    // CLINT
    input  wire data_t clint_rdata,
    output logic       clint_we,
    output logic       clint_re,
    output data_t      clint_wdata,
    // Host communication
    output logic       uart_we,
    output logic [7:0] uart_data,
    output logic       finish
);

    dev_e  dev;
    data_t load_word;
    logic  tohost_we;

    periph_bus_if plic_bus ();
    periph_bus_if clint_bus ();

    addr_decode #(
        .DRAM_OFFSET_BITS (DRAM_OFFSET_BITS)
    ) u_addr_decode (
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_we     (cpu_we),
        .cpu_re     (cpu_re),
        .cpu_ctrl   (cpu_ctrl),
        .dram_busy  (dram_busy),
        .dev        (dev),
        .dram_rd_en (dram_rd_en),
        .dram_wr_en (dram_wr_en),
        .dram_addr  (dram_addr),
        .dram_wdata (dram_wdata),
        .dram_ctrl  (dram_ctrl),
        .plic       (plic_bus.master),
        .clint      (clint_bus.master)
    );

    // Offset is captured on reads, the only accesses that return a line
    load_align u_load_align (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .access     (dram_rd_en),
        .dram_addr  (dram_addr),
        .dram_ctrl  (dram_ctrl),
        .dram_rdata (dram_rdata),
        .load_word  (load_word)
    );

    read_return u_read_return (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .dev          (dev),
        .load_word    (load_word),
        .plic         (plic_bus.monitor),
        .clint        (clint_bus.monitor),
        .read_data    (read_data),
        .is_dram_data (is_dram_data)
    );

    assign tohost_we = (dev == DEV_TOHOST) && cpu_we;

    tohost_unit u_tohost_unit (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .write     (tohost_we),
        .wdata     (cpu_wdata),
        .uart_we   (uart_we),
        .uart_data (uart_data),
        .finish    (finish)
    );

    // Peripheral buses out to plain ports
    assign plic_we        = plic_bus.we;
    assign plic_re        = plic_bus.re;
    assign plic_wdata     = plic_bus.wdata;
    assign plic_bus.rdata = plic_rdata;

    assign clint_we        = clint_bus.we;
    assign clint_re        = clint_bus.re;
    assign clint_wdata     = clint_bus.wdata;
    assign clint_bus.rdata = clint_rdata;

endmodule

`default_nettype wire

/* tohost_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tohost_unit
    import interconnect_pkg::*;
(
    input  wire        CLK,
    input  wire        rst_n,
    input  wire        write,
    input  wire data_t wdata,
    output logic       uart_we,
    output logic [7:0] uart_data,
    output logic       finish
);

    data_t r_tohost;
    logic  is_print;
    logic  is_power_off;

    assign is_print     = (r_tohost[31:16] == CMD_PRINT_CHAR);
    assign is_power_off = (r_tohost[31:16] == CMD_POWER_OFF);

    // Host word, dropped once its character has gone out
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            r_tohost <= '0;
        end else if (write) begin
            r_tohost <= wdata;
        end else if (is_print) begin
            r_tohost <= '0;
        end
    end

    // One-cycle byte strobe and sticky finish
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            uart_we <= 1'b0;
            finish  <= 1'b0;
        end else begin
            uart_we <= is_print;
            if (is_power_off) begin
                finish <= 1'b1;
            end
        end
    end

    // Character byte, only meaningful with uart_we
    always_ff @(posedge CLK) begin
        if (is_print) begin
            uart_data <= r_tohost[7:0];
        end
    end

endmodule

`default_nettype wire

/* read_return.sv */
`timescale 1ns/1ps
`default_nettype none

module read_return
    import interconnect_pkg::*;
(
    input  wire           CLK,
    input  wire           rst_n,
    input  wire dev_e     dev,
    input  wire data_t    load_word,
    periph_bus_if.monitor plic,
    periph_bus_if.monitor clint,
    output data_t         read_data,
    output logic          is_dram_data
);

    dev_e r_dev;

    // Device of the previous cycle's access
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            r_dev <= DEV_NONE;
        end else begin
            r_dev <= dev;
        end
    end

    always_comb begin
        case (r_dev)
            DEV_DRAM:  read_data = load_word;
            DEV_PLIC:  read_data = plic.rdata;
            DEV_CLINT: read_data = clint.rdata;
            // tohost and unmapped space read as zero
            default:   read_data = '0;
        endcase
    end

    assign is_dram_data = (r_dev == DEV_DRAM);

endmodule

`default_nettype wire

/* load_align.sv */
`timescale 1ns/1ps
`default_nettype none

module load_align
    import interconnect_pkg::*;
(
    input  wire        CLK,
    input  wire        rst_n,
    input  wire        access,
    input  wire addr_t dram_addr,
    input  wire ctrl_t dram_ctrl,
    input  wire line_t dram_rdata,
    output data_t      load_word
);

    logic [3:0] r_offset;
    ctrl_t      r_ctrl;
    line_t      line_shift;
    data_t      raw_word;
    logic       sign_ok;

    // Byte offset and size of the access in flight
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            r_offset <= '0;
            r_ctrl   <= CTRL_WORD;
        end else if (access) begin
            r_offset <= dram_addr[3:0];
            r_ctrl   <= dram_ctrl;
        end
    end

    // Bring the addressed byte down to bit 0
    assign line_shift = dram_rdata >> {r_offset, 3'b000};
    assign raw_word   = line_shift[31:0];
    assign sign_ok    = !r_ctrl[2];

    always_comb begin
        case (r_ctrl[1:0])
            CTRL_BYTE[1:0]: load_word = {{24{raw_word[7] & sign_ok}}, raw_word[7:0]};
            CTRL_HALF[1:0]: load_word = {{16{raw_word[15] & sign_ok}}, raw_word[15:0]};
            default:        load_word = raw_word;
        endcase
    end

endmodule

`default_nettype wire

/* addr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_decode
    import interconnect_pkg::*;
#(
    parameter int DRAM_OFFSET_BITS = DRAM_OFFSET_BITS_DEFAULT
) (
    input  wire addr_t   cpu_addr,
    input  wire data_t   cpu_wdata,
    input  wire          cpu_we,
    input  wire          cpu_re,
    input  wire ctrl_t   cpu_ctrl,
    input  wire          dram_busy,
    output dev_e         dev,
    output logic         dram_rd_en,
    output logic         dram_wr_en,
    output addr_t        dram_addr,
    output data_t        dram_wdata,
    output ctrl_t        dram_ctrl,
    periph_bus_if.master plic,
    periph_bus_if.master clint
);

    // Low DRAM_OFFSET_BITS ones
    localparam addr_t DRAM_MASK = addr_t'((64'd1 << DRAM_OFFSET_BITS) - 64'd1);

    logic [3:0] nibble;

    assign nibble = cpu_addr[31:28];

    // Region select, tohost is an exact word match
    always_comb begin
        if (cpu_addr == TOHOST_ADDR) begin
            dev = DEV_TOHOST;
        end else if (nibble == DEV_NIBBLE_DRAM_LO || nibble == DEV_NIBBLE_DRAM_HI) begin
            dev = DEV_DRAM;
        end else if (nibble == DEV_NIBBLE_PLIC) begin
            dev = DEV_PLIC;
        end else if (nibble == DEV_NIBBLE_CLINT) begin
            dev = DEV_CLINT;
        end else begin
            dev = DEV_NONE;
        end
    end

    // DRAM strobes held off while the controller is busy
    assign dram_rd_en = (dev == DEV_DRAM) && cpu_re && !dram_busy;
    assign dram_wr_en = (dev == DEV_DRAM) && cpu_we && !dram_busy;
    assign dram_addr  = cpu_addr & DRAM_MASK;
    assign dram_wdata = cpu_wdata;
    assign dram_ctrl  = cpu_ctrl;

    // Peripheral strobes only for their own region
    assign plic.we    = (dev == DEV_PLIC) && cpu_we;
    assign plic.re    = (dev == DEV_PLIC) && cpu_re;
    assign plic.wdata = cpu_wdata;

    assign clint.we    = (dev == DEV_CLINT) && cpu_we;
    assign clint.re    = (dev == DEV_CLINT) && cpu_re;
    assign clint.wdata = cpu_wdata;

endmodule

`default_nettype wire

/* periph_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Register-mapped peripheral port, plain strobes with no handshake
interface periph_bus_if
    import interconnect_pkg::*;
();

    logic  we;
    logic  re;
    data_t wdata;
    data_t rdata;

    // Address decoder side
    modport master (output we, output re, output wdata);

    // Peripheral side
    modport slave (input we, input re, input wdata, output rdata);

    // Read data observer
    modport monitor (input rdata);

endinterface

`default_nettype wire

/* interconnect_pkg.sv */
`default_nettype none

package interconnect_pkg;

    // Basic bus types
    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  data_t;
    typedef logic [127:0] line_t;

    // Load/store size code, funct3 style
    // Bits 1..0 give the size, bit 2 marks an unsigned load
    typedef logic [2:0]   ctrl_t;

    localparam ctrl_t CTRL_BYTE = 3'b000;
    localparam ctrl_t CTRL_HALF = 3'b001;
    localparam ctrl_t CTRL_WORD = 3'b010;

    // Decoded target of a CPU access
    typedef enum logic [2:0] {
        DEV_DRAM,
        DEV_PLIC,
        DEV_CLINT,
        DEV_TOHOST,
        DEV_NONE
    } dev_e;

    // Top address nibble of each region
    localparam logic [3:0] DEV_NIBBLE_DRAM_LO = 4'h0;
    localparam logic [3:0] DEV_NIBBLE_DRAM_HI = 4'h8;
    localparam logic [3:0] DEV_NIBBLE_PLIC    = 4'h5;
    localparam logic [3:0] DEV_NIBBLE_CLINT   = 4'h6;

    // Host communication register
    localparam addr_t TOHOST_ADDR = 32'h4000_8000;

    // Commands in the upper half of the tohost word
    localparam logic [15:0] CMD_PRINT_CHAR = 16'h0101;
    localparam logic [15:0] CMD_POWER_OFF  = 16'h0002;

    // 128 MB DRAM window by default
    localparam int DRAM_OFFSET_BITS_DEFAULT = 27;

endpackage

`default_nettype wire
